/* build.f */
hdl/team_01_pkg.sv
hdl/cpu_bus_if.sv
hdl/wishbone_manager.sv
hdl/team_01_regfile.sv
hdl/team_01_cpu.sv
hdl/team_01.sv
tb/wb_mem_model.sv
tb/tb_team_01.sv

/* run.sh */
#!/bin/sh
# Compile and run the team 01 regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_team_01 \
   -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_team_01 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi
echo "Simulation finished without failure"
exit 0

/* tb/tb_team_01.sv */
/*
 * Testbench for the team 01 user-area top
 * Runs small programs from a Wishbone memory model and checks the
 * GPIO result word, the halted flag and data memory
 */

`timescale 1ns/1ps
`default_nettype none

module tb_team_01;
   import team_01_pkg::*;

   localparam int HALT_TIMEOUT = 5000;
   localparam int IDLE_TIMEOUT = 20;

   logic        clk;
   logic        rst_n;
   logic        en;
   logic [33:0] gpio_in;
   logic [33:0] gpio_out;
   logic [33:0] gpio_oeb;
   logic [31:0] rd_dat;
   logic        ack;
   logic [31:0] adr;
   logic [31:0] wr_dat;
   logic [3:0]  sel;
   logic        we;
   logic        stb;
   logic        cyc;
   logic        violation;
   logic [31:0] prog_q [$];

   team_01 i_dut (
      .clk        (clk),
      .rst_n_i    (rst_n),
      .en_i       (en),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oeb_o (gpio_oeb),
      .dat_i      (rd_dat),
      .ack_i      (ack),
      .adr_o      (adr),
      .dat_o      (wr_dat),
      .sel_o      (sel),
      .we_o       (we),
      .stb_o      (stb),
      .cyc_o      (cyc)
   );

   wb_mem_model i_mem (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .cyc_i       (cyc),
      .stb_i       (stb),
      .we_i        (we),
      .adr_i       (adr),
      .dat_i       (wr_dat),
      .sel_i       (sel),
      .dat_o       (rd_dat),
      .ack_o       (ack),
      .violation_o (violation)
   );

   always #2 clk = ~clk;

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   always @(negedge clk) begin
      if (violation) begin
         $display("Memory model saw a Wishbone protocol violation");
         abort_run();
      end
   end

   // Register form and immediate form encoders
   function automatic logic [31:0] reg_instr(opcode_e op, logic [2:0] rd,
                                             logic [2:0] rs1, logic [2:0] rs2);
      return {op, rd, rs1, rs2, 19'd0};
   endfunction

   function automatic logic [31:0] imm_instr(opcode_e op, logic [2:0] rd,
                                             logic [15:0] imm);
      return {op, rd, 9'd0, imm};
   endfunction

   // Reset, load code while held, check idle outputs right after release
   task automatic load_and_start();
      @(posedge clk);
      rst_n <= 1'b0;
      en    <= 1'b1;
      for (int i = 0; i < 1024; i++) begin
         i_mem.code_mem[i] = {HALT, 28'(i)};
      end
      foreach (prog_q[i]) begin
         i_mem.code_mem[i] = prog_q[i];
      end
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_equal("cyc_o", 32'd0, 32'(cyc));
      check_equal("stb_o", 32'd0, 32'(stb));
      check_equal("we_o", 32'd0, 32'(we));
      check_equal("gpio_out_o[31:0]", 32'd0, gpio_out[31:0]);
      check_equal("gpio_out_o[33:32]", 32'd0, 32'(gpio_out[33:32]));
      // Every pin is an output
      check_equal("gpio_oeb_o[31:0]", 32'd0, gpio_oeb[31:0]);
      check_equal("gpio_oeb_o[33:32]", 32'd0, 32'(gpio_oeb[33:32]));
   endtask

   task automatic wait_for_halt();
      int cycles;
      cycles = 0;
      while (!gpio_out[33]) begin
         @(negedge clk);
         cycles++;
         if (cycles > HALT_TIMEOUT) begin
            $display("Timeout: CPU did not halt within %0d cycles", HALT_TIMEOUT);
            abort_run();
         end
      end
   endtask

   task automatic alu_sequence();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] expected;
      a = 32'h0000_1234;
      b = 32'h0000_0f0f;
      // r3 = a + b, r4 = b - a, r5 = r4 & r3, r6 = r5 ^ a
      expected = (((b - a) & (a + b)) ^ a);
      prog_q.delete();
      prog_q.push_back(imm_instr(LDI, 3'd1, 16'h1234));
      prog_q.push_back(imm_instr(LDI, 3'd2, 16'h0f0f));
      prog_q.push_back(reg_instr(ADD, 3'd3, 3'd1, 3'd2));
      prog_q.push_back(reg_instr(SUB, 3'd4, 3'd2, 3'd1));
      prog_q.push_back(reg_instr(AND, 3'd5, 3'd4, 3'd3));
      prog_q.push_back(reg_instr(XOR, 3'd6, 3'd5, 3'd1));
      prog_q.push_back(imm_instr(OUT, 3'd6, 16'd0));
      prog_q.push_back(imm_instr(HALT, 3'd0, 16'd0));
      load_and_start();
      wait_for_halt();
      check_equal("gpio_out_o[31:0]", expected, gpio_out[31:0]);
      // Halted stays set, running cleared
      repeat (5) @(negedge clk);
      check_equal("gpio_out_o[33:32]", 32'd2, 32'(gpio_out[33:32]));
   endtask

   task automatic store_then_load();
      logic [31:0] value;
      value = 32'h0000_beef + 32'h0000_beef;
      prog_q.delete();
      prog_q.push_back(imm_instr(LDI, 3'd1, 16'hbeef));
      prog_q.push_back(reg_instr(ADD, 3'd1, 3'd1, 3'd1));
      prog_q.push_back(imm_instr(ST, 3'd1, 16'd5));
      // Clear r1 so only the load can bring the value back
      prog_q.push_back(reg_instr(XOR, 3'd1, 3'd1, 3'd1));
      prog_q.push_back(imm_instr(LD, 3'd2, 16'd5));
      prog_q.push_back(imm_instr(OUT, 3'd2, 16'd0));
      prog_q.push_back(imm_instr(HALT, 3'd0, 16'd0));
      load_and_start();
      wait_for_halt();
      check_equal("data_mem[5]", value, i_mem.data_mem[5]);
      check_equal("gpio_out_o[31:0]", value, gpio_out[31:0]);
   endtask

   // r1 counts down, r2 sums, r3 holds one
   task automatic countdown_program(input logic [15:0] n);
      prog_q.delete();
      prog_q.push_back(imm_instr(LDI, 3'd1, n));
      prog_q.push_back(imm_instr(LDI, 3'd2, 16'd0));
      prog_q.push_back(imm_instr(LDI, 3'd3, 16'd1));
      prog_q.push_back(imm_instr(BEQZ, 3'd1, 16'd7));
      prog_q.push_back(reg_instr(ADD, 3'd2, 3'd2, 3'd1));
      prog_q.push_back(reg_instr(SUB, 3'd1, 3'd1, 3'd3));
      prog_q.push_back(imm_instr(JMP, 3'd0, 16'd3));
      prog_q.push_back(imm_instr(OUT, 3'd2, 16'd0));
      prog_q.push_back(imm_instr(HALT, 3'd0, 16'd0));
   endtask

   task automatic countdown_sum();
      logic [31:0] n;
      n = 32'd10;
      countdown_program(n[15:0]);
      load_and_start();
      wait_for_halt();
      check_equal("gpio_out_o[31:0]", n * (n + 32'd1) / 32'd2, gpio_out[31:0]);
   endtask

   task automatic enable_pause();
      logic [31:0] n;
      int          cycles;
      n = 32'd12;
      countdown_program(n[15:0]);
      load_and_start();
      repeat (40) @(posedge clk);
      en <= 1'b0;
      // Let the transfer in flight finish
      cycles = 0;
      @(negedge clk);
      while (cyc) begin
         @(negedge clk);
         cycles++;
         if (cycles > IDLE_TIMEOUT) begin
            $display("Timeout: bus cycle did not end after enable dropped");
            abort_run();
         end
      end
      repeat (50) begin
         @(negedge clk);
         check_equal("cyc_o", 32'd0, 32'(cyc));
      end
      // Paused mid-program, still running and not halted
      check_equal("gpio_out_o[33:32]", 32'd1, 32'(gpio_out[33:32]));
      @(posedge clk);
      en <= 1'b1;
      wait_for_halt();
      check_equal("gpio_out_o[31:0]", n * (n + 32'd1) / 32'd2, gpio_out[31:0]);
   endtask

   initial begin
      void'($urandom(32'hf8af_fc34));
      clk     = 1'b0;
      rst_n   = 1'b0;
      en      = 1'b0;
      gpio_in = '0;
      alu_sequence();
      store_then_load();
      countdown_sum();
      enable_pause();
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/wb_mem_model.sv */
/*
 * Wishbone memory model for the team 01 testbench
 * Code and data words behind a random acknowledge delay, plus a
 * monitor that flags classic-cycle protocol errors
 */

`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        violation_o
);
   import team_01_pkg::*;

   // Code from address zero, data from DATA_BASE
   logic [31:0] code_mem [1024];
   logic [31:0] data_mem [256];
   logic        busy_q;
   logic [1:0]  delay_q;
   logic        hold_q;
   logic        ended_q;
   logic [68:0] snap_q;
   logic        is_data;

   assign is_data = (adr_i >= DATA_BASE);

   // Every data word carries its own index
   initial begin
      for (int i = 0; i < 256; i++) begin
         data_mem[i] = {24'h5a5a5a, 8'(i)};
      end
   end

   // Responder, draws a new delay at the start of each cycle
   always @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o   <= 1'b0;
         busy_q  <= 1'b0;
         delay_q <= 2'd0;
      end else if (ack_o) begin
         ack_o  <= 1'b0;
         busy_q <= 1'b0;
      end else if (cyc_i && stb_i) begin
         if (!busy_q) begin
            busy_q  <= 1'b1;
            delay_q <= 2'($urandom % 4);
         end else if (delay_q != 2'd0) begin
            delay_q <= delay_q - 2'd1;
         end else begin
            ack_o <= 1'b1;
            if (we_i && is_data) begin
               data_mem[adr_i[9:2]] = dat_i;
            end else if (is_data) begin
               dat_o <= data_mem[adr_i[9:2]];
            end else begin
               dat_o <= code_mem[adr_i[11:2]];
            end
         end
      end
   end

   // Protocol monitor, sticky error flag
   always @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_q      <= 1'b0;
         ended_q     <= 1'b0;
         violation_o <= 1'b0;
      end else begin
         hold_q  <= stb_i && !ack_o;
         ended_q <= stb_i && ack_o;
         snap_q  <= {adr_i, dat_i, sel_i, we_i};
         if (stb_i && !cyc_i) begin
            $display("Protocol error: STB high while CYC is low at %0t", $time);
            violation_o <= 1'b1;
         end
         // Word accesses only
         if (stb_i && sel_i != 4'b1111) begin
            $display("Protocol error: byte select not all ones at %0t", $time);
            violation_o <= 1'b1;
         end
         // Stalled request must not move or vanish
         if (hold_q && (!stb_i || snap_q != {adr_i, dat_i, sel_i, we_i})) begin
            $display("Protocol error: request changed before ACK at %0t", $time);
            violation_o <= 1'b1;
         end
         if (ended_q && cyc_i) begin
            $display("Protocol error: CYC did not drop after ACK at %0t", $time);
            violation_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/team_01.sv */
/*
 * Team 01 user-area top
 * Load/store CPU behind a Wishbone manager, with the CPU output word
 * and state flags on the GPIO pins
 */

`timescale 1ns/1ps
`default_nettype none

module team_01 (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        en_i,

   // Breakout board pins
   input  logic [33:0] gpio_in_i,
   output logic [33:0] gpio_out_o,
   output logic [33:0] gpio_oeb_o,

   // Wishbone interconnect
   input  logic [31:0] dat_i,
   input  logic        ack_i,
   output logic [31:0] adr_o,
   output logic [31:0] dat_o,
   output logic [3:0]  sel_o,
   output logic        we_o,
   output logic        stb_o,
   output logic        cyc_o
);

   cpu_bus_if bus ();

   logic [31:0] gpio_word;
   logic        running;
   logic        halted;

   wishbone_manager i_wb_manager (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (bus.manager),
      .dat_i   (dat_i),
      .ack_i   (ack_i),
      .adr_o   (adr_o),
      .dat_o   (dat_o),
      .sel_o   (sel_o),
      .we_o    (we_o),
      .stb_o   (stb_o),
      .cyc_o   (cyc_o)
   );

   team_01_cpu i_cpu (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .en_i        (en_i),
      .bus         (bus.cpu),
      .gpio_word_o (gpio_word),
      .running_o   (running),
      .halted_o    (halted)
   );

   // Bit 33 halted, bit 32 running, low word from OUT
   assign gpio_out_o = {halted, running, gpio_word};

   // Active low, every pin drives
   assign gpio_oeb_o = '0;

endmodule

`default_nettype wire

/* hdl/team_01_cpu.sv */
/*
 * Minimal load/store CPU
 * Fetches over the bus manager, executes one instruction per fetch,
 * drives a 32-bit output word and running/halted flags
 */

`timescale 1ns/1ps
`default_nettype none

module team_01_cpu (
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        en_i,
   cpu_bus_if.cpu      bus,
   output logic [31:0] gpio_word_o,
   output logic        running_o,
   output logic        halted_o
);
   import team_01_pkg::*;

   typedef enum logic [2:0] {
      FETCH_REQ,
      FETCH_WAIT,
      EXECUTE,
      MEM_REQ,
      MEM_WAIT,
      HALTED
   } cpu_state_e;

   cpu_state_e            state_q;
   logic [15:0]           pc_q;
   instr_u                ir_q;
   opcode_e               op;
   logic                  is_alu;
   logic                  issue;
   logic                  running_q;
   logic [REG_ADDR_W-1:0] rd_addr_a;
   logic [31:0]           rd_data_a;
   logic [31:0]           rd_data_b;
   logic                  wr_en;
   logic [REG_ADDR_W-1:0] wr_addr;
   logic [31:0]           wr_data;
   logic [31:0]           alu_res;

   assign op     = ir_q.mem.opcode;
   assign is_alu = (op == ADD) || (op == SUB) || (op == AND) || (op == XOR);

   // Port A reads rs1 for ALU ops, rd otherwise (ST, OUT, BEQZ)
   assign rd_addr_a = is_alu ? ir_q.alu.rs1 : ir_q.alu.rd;

   team_01_regfile i_regfile (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rd_addr_a_i (rd_addr_a),
      .rd_addr_b_i (ir_q.alu.rs2),
      .rd_data_a_o (rd_data_a),
      .rd_data_b_o (rd_data_b),
      .wr_en_i     (wr_en),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (wr_data)
   );

   always_comb begin
      case (op)
         SUB:     alu_res = rd_data_a - rd_data_b;
         AND:     alu_res = rd_data_a & rd_data_b;
         XOR:     alu_res = rd_data_a ^ rd_data_b;
         default: alu_res = rd_data_a + rd_data_b;
      endcase
   end

   // Register write-back
   always_comb begin
      wr_en   = 1'b0;
      wr_addr = ir_q.mem.rd;
      wr_data = alu_res;
      if (state_q == EXECUTE) begin
         if (op == LDI) begin
            wr_en   = 1'b1;
            wr_data = {16'h0000, ir_q.mem.imm};
         end else if (is_alu) begin
            wr_en = 1'b1;
         end
      end else if (state_q == MEM_WAIT && op == LD && !bus.busy_o) begin
         // Load data valid once busy falls
         wr_en   = 1'b1;
         wr_data = bus.cpu_dat_o;
      end
   end

   // New requests only when enabled and the manager is free
   assign issue = en_i && !bus.busy_o;

   assign bus.read_i  = issue && ((state_q == FETCH_REQ) ||
                                  (state_q == MEM_REQ && op == LD));
   assign bus.write_i = issue && state_q == MEM_REQ && op == ST;

   // Fetch at pc*4 from zero, data at base plus imm*4
   assign bus.adr_i = (state_q == MEM_REQ) ?
                      DATA_BASE + {14'h0000, ir_q.mem.imm, 2'b00} :
                      {14'h0000, pc_q, 2'b00};
   assign bus.cpu_dat_i = rd_data_a;
   assign bus.sel_i     = WB_SEL_ALL;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= FETCH_REQ;
         pc_q        <= '0;
         gpio_word_o <= '0;
         running_q   <= 1'b0;
      end else begin
         case (state_q)
            FETCH_REQ: begin
               if (issue) begin
                  state_q   <= FETCH_WAIT;
                  running_q <= 1'b1;
               end
            end
            // Busy is high the cycle after the request, so no early exit
            FETCH_WAIT: begin
               if (!bus.busy_o) begin
                  state_q <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc_q    <= pc_q + 16'd1;
               state_q <= FETCH_REQ;
               case (op)
                  LD, ST: state_q <= MEM_REQ;
                  BEQZ: begin
                     if (rd_data_a == '0) begin
                        pc_q <= ir_q.mem.imm;
                     end
                  end
                  JMP: pc_q <= ir_q.mem.imm;
                  OUT: gpio_word_o <= rd_data_a;
                  // Register writes handled by write-back logic
                  LDI, ADD, SUB, AND, XOR: begin
                  end
                  default: begin
                     state_q   <= HALTED;
                     running_q <= 1'b0;
                  end
               endcase
            end
            MEM_REQ: begin
               if (issue) begin
                  state_q <= MEM_WAIT;
               end
            end
            MEM_WAIT: begin
               if (!bus.busy_o) begin
                  state_q <= FETCH_REQ;
               end
            end
            // Only reset leaves HALTED
            default: state_q <= HALTED;
         endcase
      end
   end

   // Instruction register, loaded when the fetch completes
   always_ff @(posedge clk) begin
      if (state_q == FETCH_WAIT && !bus.busy_o) begin
         ir_q <= instr_u'(bus.cpu_dat_o);
      end
   end

   assign running_o = running_q;
   assign halted_o  = (state_q == HALTED);

   a_one_dir: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(bus.read_i && bus.write_i))
      else $error("CPU raised read and write in the same cycle");

   // Once halted the CPU stays halted and quiet on the bus
   a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
      halted_o |=> (halted_o && !bus.read_i && !bus.write_i))
      else $error("CPU left HALTED or made a request while halted");

endmodule

`default_nettype wire

/* hdl/team_01_regfile.sv */
/*
 * CPU register file
 * Eight 32-bit registers, two asynchronous reads, one synchronous write
 */

`timescale 1ns/1ps
`default_nettype none

module team_01_regfile (
   input  logic                               clk,
   input  logic                               rst_n_i,
   input  logic [team_01_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
   input  logic [team_01_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
   output logic [31:0]                        rd_data_a_o,
   output logic [31:0]                        rd_data_b_o,
   input  logic                               wr_en_i,
   input  logic [team_01_pkg::REG_ADDR_W-1:0] wr_addr_i,
   input  logic [31:0]                        wr_data_i
);
   import team_01_pkg::*;

   logic [31:0] regs_q [NUM_REGS];

   // No hardwired zero, r0 is a normal register
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en_i) begin
         regs_q[wr_addr_i] <= wr_data_i;
      end
   end

   // Reads see the old value during a write
   assign rd_data_a_o = regs_q[rd_addr_a_i];
   assign rd_data_b_o = regs_q[rd_addr_b_i];

endmodule

`default_nettype wire

/* hdl/wishbone_manager.sv */
/*
 * Wishbone manager
 * Turns one CPU read or write request into a classic Wishbone cycle
 * and returns the read data with a busy flag
 */

`timescale 1ns/1ps
`default_nettype none

module wishbone_manager (
   input  logic        clk,
   input  logic        rst_n_i,
   cpu_bus_if.manager  bus,
   input  logic [31:0] dat_i,
   input  logic        ack_i,
   output logic [31:0] adr_o,
   output logic [31:0] dat_o,
   output logic [3:0]  sel_o,
   output logic        we_o,
   output logic        stb_o,
   output logic        cyc_o
);

   typedef enum logic {
      IDLE,
      ACTIVE
   } wb_state_e;

   wb_state_e state_q;
   logic      req;

   assign req = bus.read_i || bus.write_i;

   // Cycle control and busy flag
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         cyc_o      <= 1'b0;
         stb_o      <= 1'b0;
         we_o       <= 1'b0;
         bus.busy_o <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (req) begin
                  state_q    <= ACTIVE;
                  cyc_o      <= 1'b1;
                  stb_o      <= 1'b1;
                  we_o       <= bus.write_i;
                  bus.busy_o <= 1'b1;
               end else begin
                  // Busy drops one cycle after the bus cycle closed
                  bus.busy_o <= 1'b0;
               end
            end
            ACTIVE: begin
               // Hold everything until the slave acknowledges
               if (ack_i) begin
                  state_q <= IDLE;
                  cyc_o   <= 1'b0;
                  stb_o   <= 1'b0;
                  we_o    <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Address, write data and read data
   always_ff @(posedge clk) begin
      if (state_q == IDLE && req) begin
         adr_o <= bus.adr_i;
         dat_o <= bus.cpu_dat_i;
         sel_o <= bus.sel_i;
      end
      if (state_q == ACTIVE && ack_i && !we_o) begin
         bus.cpu_dat_o <= dat_i;
      end
   end

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
      stb_o |-> cyc_o)
      else $error("Wishbone strobe high outside a bus cycle");

   // Slave may stall, outputs must not move meanwhile
   a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
      (stb_o && !ack_i) |=> ($stable(adr_o) && $stable(dat_o) &&
                             $stable(sel_o) && $stable(we_o)))
      else $error("Wishbone outputs changed before acknowledge");

   // CPU must wait for the previous transfer
   a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
      bus.busy_o |-> !req)
      else $error("CPU request arrived while the manager was busy");

endmodule

`default_nettype wire

/* hdl/cpu_bus_if.sv */
/*
 * CPU to bus manager link
 * Single-cycle read/write requests and the busy/read-data response
 */

`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

   // Request side, driven by the CPU
   logic [31:0] cpu_dat_i;
   logic [31:0] adr_i;
   logic [3:0]  sel_i;
   logic        write_i;
   logic        read_i;

   // Response side, driven by the manager
   logic [31:0] cpu_dat_o;
   logic        busy_o;

   modport cpu (
      output cpu_dat_i, adr_i, sel_i, write_i, read_i,
      input  cpu_dat_o, busy_o
   );

   modport manager (
      input  cpu_dat_i, adr_i, sel_i, write_i, read_i,
      output cpu_dat_o, busy_o
   );

endinterface

`default_nettype wire

/* hdl/team_01_pkg.sv */
/*
 * Team 01 shared definitions
 * Instruction encodings, opcodes and Wishbone bus constants
 * for the load/store CPU and its bus manager
 */

`default_nettype none

package team_01_pkg;

   // Register file geometry
   localparam int REG_ADDR_W = 3;
   localparam int NUM_REGS   = 8;

   // Word accesses only
   localparam logic [3:0] WB_SEL_ALL = 4'b1111;

   // Byte base of data memory, instructions start at zero
   localparam logic [31:0] DATA_BASE = 32'h0000_1000;

   typedef enum logic [3:0] {
      LDI  = 4'h0,
      LD   = 4'h1,
      ST   = 4'h2,
      ADD  = 4'h3,
      SUB  = 4'h4,
      AND  = 4'h5,
      XOR  = 4'h6,
      BEQZ = 4'h7,
      JMP  = 4'h8,
      OUT  = 4'h9,
      // Unlisted codes also stop the CPU
      HALT = 4'hF
   } opcode_e;

   // Register form, rd = rs1 op rs2
   typedef struct packed {
      opcode_e                 opcode;
      logic [REG_ADDR_W-1:0]   rd;
      logic [REG_ADDR_W-1:0]   rs1;
      logic [REG_ADDR_W-1:0]   rs2;
      logic [18:0]             unused;
   } instr_alu_t;

   // Immediate form, imm is a word address or a constant
   typedef struct packed {
      opcode_e                 opcode;
      logic [REG_ADDR_W-1:0]   rd;
      logic [8:0]              unused;
      logic [15:0]             imm;
   } instr_mem_t;

   // Opcode and rd sit in the same bits of both views
   typedef union packed {
      instr_alu_t alu;
      instr_mem_t mem;
   } instr_u;

endpackage

`default_nettype wire
